// ==== dcache_top.f ====
hw/dcache_pkg.sv
hw/dcache_way.sv
hw/dcache_ctrl.sv
hw/dcache_way_select.sv
hw/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - hw/dcache_pkg.sv
      - hw/dcache_way.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_way_select.sv
      - hw/dcache_top.sv
  - target: test
    files:
      - tests/dcache_mem_model.sv
      - tests/dcache_tb.sv

// ==== tests/dcache_tb.sv ====
`default_nettype none

module dcache_tb;

    localparam int clk_period = 4;
    localparam int mem_words = 512;
    localparam logic [63:0] preset_mult = 64'h9e37_79b9_7f4a_7c15;
    localparam int directed_accesses = 17;
    localparam int random_accesses = 300;

    logic clk;
    logic reset;
    logic dreq_valid;
    logic [dcache_pkg::addr_width-1:0] dreq_addr;
    logic [dcache_pkg::lane_count-1:0] dreq_strobe;
    logic [dcache_pkg::word_width-1:0] dreq_wdata;
    logic dresp_data_ok;
    logic [dcache_pkg::word_width-1:0] dresp_rdata;
    logic creq_valid;
    logic creq_is_write;
    logic [dcache_pkg::addr_width-1:0] creq_addr;
    logic [dcache_pkg::word_width-1:0] creq_wdata;
    logic cresp_ready;
    logic cresp_last;
    logic [dcache_pkg::word_width-1:0] cresp_rdata;

    // shadow of what memory plus cache should hold
    logic [63:0] shadow [mem_words];
    bit written [mem_words];

    logic [63:0] expect_q[$];
    bit is_read_q[$];

    int errors = 0;
    int errors_seen = 0;
    int checks = 0;
    int tests_run = 0;
    int refill_bursts = 0;
    int wb_bursts = 0;
    int bus_cycles = 0;
    logic [31:0] wb_addr = '0;

    dcache_top i_dut (
        .clk, .reset,
        .dreq_valid, .dreq_addr, .dreq_strobe, .dreq_wdata,
        .dresp_data_ok, .dresp_rdata,
        .creq_valid, .creq_is_write, .creq_addr, .creq_wdata,
        .cresp_ready, .cresp_last, .cresp_rdata
    );

    dcache_mem_model i_mem (
        .clk, .reset,
        .creq_valid, .creq_is_write, .creq_addr, .creq_wdata,
        .cresp_ready, .cresp_last, .cresp_rdata
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [63:0] preset_word(input int unsigned word_addr);
        return 64'(word_addr) * preset_mult;
    endfunction

    // applies the access to the shadow, returns the word a read would see
    function automatic logic [63:0] predict_access(input logic [31:0] addr,
                                                   input logic [7:0] strobe,
                                                   input logic [63:0] wdata);
        int unsigned w;
        logic [63:0] word;
        w = addr >> 3;
        word = written[w] ? shadow[w] : preset_word(w);
        for (int l = 0; l < 8; l++) begin
            if (strobe[l]) begin
                word[8*l +: 8] = wdata[8*l +: 8];
            end
        end
        if (strobe != 0) begin
            shadow[w] = word;
            written[w] = 1'b1;
        end
        return word;
    endfunction

    // starts at an edge plus one, returns one unit after the data_ok edge
    task automatic run_access(input logic [31:0] addr, input logic [7:0] strobe,
                              input logic [63:0] wdata, output int latency);
        expect_q.push_back(predict_access(addr, strobe, wdata));
        is_read_q.push_back(strobe == 0);
        dreq_valid = 1'b1;
        dreq_addr = addr;
        dreq_strobe = strobe;
        dreq_wdata = wdata;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!dresp_data_ok);
        #1;
        dreq_valid = 1'b0;
    endtask

    task automatic check_true(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("error at time %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got == expected) else begin
            $display("error at time %0t: %s got %0h expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == errors_seen) ? "passed" : "failed", errors - errors_seen);
        errors_seen = errors;
    endtask

    // compares every read response against the shadow
    always @(posedge clk) begin
        logic [63:0] expected;
        bit is_read;
        if (!reset && dresp_data_ok) begin
            checks++;
            assert (expect_q.size() > 0) else begin
                $display("error at time %0t: data_ok with no access outstanding", $time);
                errors++;
            end
            if (expect_q.size() > 0) begin
                expected = expect_q.pop_front();
                is_read = is_read_q.pop_front();
                if (is_read) begin
                    assert (dresp_rdata == expected) else begin
                        $display("error at time %0t: dresp_rdata got %h expected %h",
                                 $time, dresp_rdata, expected);
                        errors++;
                    end
                end
            end
        end
    end

    // bus traffic seen by the tests
    always @(posedge clk) begin
        if (!reset && creq_valid) begin
            bus_cycles++;
            if (cresp_ready && cresp_last) begin
                if (creq_is_write) begin
                    wb_bursts++;
                    wb_addr = creq_addr;
                end else begin
                    refill_bursts++;
                end
            end
        end
    end

    initial begin
        #((4 + 400 * (directed_accesses + random_accesses)) * clk_period);
        $display("watchdog: the run did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        int unsigned seed_val;
        int lat;
        int r0;
        int w0;
        int b0;
        logic [31:0] addr;
        logic [7:0] strobe;
        seed_val = $urandom(50);
        reset = 1'b1;
        dreq_valid = 1'b0;
        dreq_addr = '0;
        dreq_strobe = '0;
        dreq_wdata = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        r0 = refill_bursts;
        w0 = wb_bursts;
        run_access(32'h0000_0040, 8'h00, '0, lat);
        check_true(refill_bursts - r0 == 1, "a cold read did not give exactly one refill burst");
        check_true(wb_bursts == w0, "a cold read caused a writeback");
        finish_test("cold read");

        run_access(32'h0000_0088, 8'hff, 64'h0123_4567_89ab_cdef, lat);
        b0 = bus_cycles;
        run_access(32'h0000_0088, 8'h00, '0, lat);
        check_true(bus_cycles == b0, "the read after a write went to the bus");
        // valid taken at the first edge, respond two cycles later
        check_value("data_ok latency", lat, 3);
        finish_test("write then read");

        run_access(32'h0000_0108, 8'h0f, 64'h1111_1111_1111_1111, lat);
        run_access(32'h0000_0108, 8'hf0, 64'h2222_2222_2222_2222, lat);
        run_access(32'h0000_0108, 8'h3c, 64'h3333_3333_3333_3333, lat);
        run_access(32'h0000_0108, 8'h81, 64'h4444_4444_4444_4444, lat);
        run_access(32'h0000_0108, 8'h00, '0, lat);
        finish_test("strobed merge");

        // set 3: a, b, a, c, then a again
        run_access(32'h0000_0180, 8'h00, '0, lat);
        run_access(32'h0000_0580, 8'h00, '0, lat);
        run_access(32'h0000_0180, 8'h00, '0, lat);
        run_access(32'h0000_0980, 8'h00, '0, lat);
        b0 = bus_cycles;
        run_access(32'h0000_0180, 8'h00, '0, lat);
        check_true(bus_cycles == b0, "the LRU evicted the recently used line");
        finish_test("lru order");

        run_access(32'h0000_0200, 8'hff, 64'haaaa_0000_0000_0001, lat);
        run_access(32'h0000_0600, 8'hff, 64'hbbbb_0000_0000_0002, lat);
        w0 = wb_bursts;
        run_access(32'h0000_0a00, 8'hff, 64'hcccc_0000_0000_0003, lat);
        check_true(wb_bursts - w0 == 1, "the third dirty line did not force one writeback");
        check_value("creq_addr", wb_addr, 32'h0000_0200);
        run_access(32'h0000_0200, 8'h00, '0, lat);
        finish_test("dirty writeback");

        for (int i = 0; i < random_accesses; i++) begin
            addr = ($urandom % mem_words) << 3;
            strobe = ($urandom % 2) ? 8'($urandom) : 8'h00;
            run_access(addr, strobe, {$urandom, $urandom}, lat);
        end
        finish_test("random accesses");

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/dcache_mem_model.sv ====
`default_nettype none

module dcache_mem_model (
    input  logic clk,
    input  logic reset,

    input  logic creq_valid,
    input  logic creq_is_write,
    input  logic [dcache_pkg::addr_width-1:0] creq_addr,
    input  logic [dcache_pkg::word_width-1:0] creq_wdata,
    output logic cresp_ready,
    output logic cresp_last,
    output logic [dcache_pkg::word_width-1:0] cresp_rdata
);

    // 4 KiB of backing store, wraps above that
    localparam int mem_words = 512;
    localparam logic [63:0] preset_mult = 64'h9e37_79b9_7f4a_7c15;

    logic [dcache_pkg::word_width-1:0] mem [mem_words];
    int unsigned beat;

    function automatic int unsigned word_index(input logic [31:0] line_addr,
                                               input int unsigned b);
        return ((line_addr >> 3) + b) % mem_words;
    endfunction

    // preset content is the word address times an odd constant
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 64'(i) * preset_mult;
        end
        beat = 0;
        cresp_ready = 1'b0;
        cresp_last = 1'b0;
        cresp_rdata = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            beat = 0;
        end else if (creq_valid && cresp_ready) begin
            if (creq_is_write) begin
                mem[word_index(creq_addr, beat)] = creq_wdata;
            end
            beat = cresp_last ? 0 : beat + 1;
        end
        // responses move just after the edge
        #1;
        cresp_ready = ($urandom % 4) != 0;
        cresp_last = (beat == dcache_pkg::words_per_line - 1);
        cresp_rdata = mem[word_index(creq_addr, beat)];
    end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  logic clk,
    input  logic reset,

    input  logic dreq_valid,
    input  logic [dcache_pkg::addr_width-1:0] dreq_addr,
    input  logic [dcache_pkg::lane_count-1:0] dreq_strobe,
    input  logic [dcache_pkg::word_width-1:0] dreq_wdata,
    output logic dresp_data_ok,
    output logic [dcache_pkg::word_width-1:0] dresp_rdata,

    output logic creq_valid,
    output logic creq_is_write,
    output logic [dcache_pkg::addr_width-1:0] creq_addr,
    output logic [dcache_pkg::word_width-1:0] creq_wdata,
    input  logic cresp_ready,
    input  logic cresp_last,
    input  logic [dcache_pkg::word_width-1:0] cresp_rdata
);

    logic [dcache_pkg::index_bits-1:0] index;
    logic [dcache_pkg::offset_bits-1:0] offset;
    logic [dcache_pkg::tag_bits-1:0] lookup_tag;

    logic any_hit;
    logic [$clog2(dcache_pkg::way_num)-1:0] victim_way;
    logic victim_dirty;
    logic [dcache_pkg::tag_bits-1:0] victim_tag;
    logic [dcache_pkg::word_width-1:0] sel_word;

    logic [dcache_pkg::way_num-1:0] fill_en;
    logic [dcache_pkg::way_num-1:0] store_en;
    logic [dcache_pkg::word_width-1:0] fill_word;
    logic [dcache_pkg::lane_count-1:0] store_strobe;
    dcache_pkg::word_lanes_t store_word;
    logic fill_last;
    logic touch;

    // per-way lookup results
    logic [dcache_pkg::way_num-1:0] way_hit;
    logic [dcache_pkg::way_num-1:0] way_dirty;
    logic [dcache_pkg::way_num-1:0][dcache_pkg::tag_bits-1:0] way_tag;
    logic [dcache_pkg::way_num-1:0][dcache_pkg::word_width-1:0] way_rdata;

    dcache_ctrl i_ctrl (
        .clk, .reset,
        .dreq_valid, .dreq_addr, .dreq_strobe, .dreq_wdata,
        .dresp_data_ok, .dresp_rdata,
        .creq_valid, .creq_is_write, .creq_addr, .creq_wdata,
        .cresp_ready, .cresp_last, .cresp_rdata,
        .index, .offset, .lookup_tag,
        .any_hit, .victim_way, .victim_dirty, .victim_tag, .sel_word,
        .fill_en, .store_en, .fill_word, .store_strobe, .store_word,
        .fill_last, .touch
    );

    for (genvar w = 0; w < dcache_pkg::way_num; w++) begin : g_way
        dcache_way i_way (
            .clk, .reset,
            .index, .offset, .lookup_tag,
            .fill_en(fill_en[w]),
            .store_en(store_en[w]),
            .fill_word, .store_strobe, .store_word, .fill_last,
            .hit(way_hit[w]),
            .dirty(way_dirty[w]),
            .tag_out(way_tag[w]),
            .rdata(way_rdata[w])
        );
    end

    dcache_way_select i_select (
        .clk, .reset,
        .index, .touch,
        .hit(way_hit),
        .dirty(way_dirty),
        .tag(way_tag),
        .rdata(way_rdata),
        .any_hit, .victim_way, .victim_dirty, .victim_tag, .sel_word
    );

endmodule

`default_nettype wire

// ==== hw/dcache_way_select.sv ====
`default_nettype none

module dcache_way_select (
    input  logic clk,
    input  logic reset,

    input  logic [dcache_pkg::index_bits-1:0] index,
    input  logic touch,

    input  logic [dcache_pkg::way_num-1:0] hit,
    input  logic [dcache_pkg::way_num-1:0] dirty,
    input  logic [dcache_pkg::way_num-1:0][dcache_pkg::tag_bits-1:0] tag,
    input  logic [dcache_pkg::way_num-1:0][dcache_pkg::word_width-1:0] rdata,

    output logic any_hit,
    output logic [$clog2(dcache_pkg::way_num)-1:0] victim_way,
    output logic victim_dirty,
    output logic [dcache_pkg::tag_bits-1:0] victim_tag,
    output logic [dcache_pkg::word_width-1:0] sel_word
);

    // per set, the way to evict next
    logic [dcache_pkg::set_num-1:0] lru;
    logic [$clog2(dcache_pkg::way_num)-1:0] hit_way;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            if (hit[w]) begin
                hit_way = w[$clog2(dcache_pkg::way_num)-1:0];
            end
        end
    end

    assign any_hit = |hit;

    // on a hit the hitting way stands in, otherwise the LRU way.
    // during writeback nothing hits, so this drains the victim line
    assign victim_way = any_hit ? hit_way : lru[index];
    assign victim_dirty = dirty[victim_way];
    assign victim_tag = tag[victim_way];
    assign sel_word = rdata[victim_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (touch) begin
            // other way becomes the next victim
            lru[index] <= ~victim_way;
        end
    end

    single_hit: assert property (
        @(posedge clk) disable iff (reset) $onehot0(hit)
    );

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
    input  logic clk,
    input  logic reset,

    // processor side
    input  logic dreq_valid,
    input  logic [dcache_pkg::addr_width-1:0] dreq_addr,
    input  logic [dcache_pkg::lane_count-1:0] dreq_strobe,
    input  logic [dcache_pkg::word_width-1:0] dreq_wdata,
    output logic dresp_data_ok,
    output logic [dcache_pkg::word_width-1:0] dresp_rdata,

    // memory side
    output logic creq_valid,
    output logic creq_is_write,
    output logic [dcache_pkg::addr_width-1:0] creq_addr,
    output logic [dcache_pkg::word_width-1:0] creq_wdata,
    input  logic cresp_ready,
    input  logic cresp_last,
    input  logic [dcache_pkg::word_width-1:0] cresp_rdata,

    // to the ways
    output logic [dcache_pkg::index_bits-1:0] index,
    output logic [dcache_pkg::offset_bits-1:0] offset,
    output logic [dcache_pkg::tag_bits-1:0] lookup_tag,

    // from the way selector
    input  logic any_hit,
    input  logic [$clog2(dcache_pkg::way_num)-1:0] victim_way,
    input  logic victim_dirty,
    input  logic [dcache_pkg::tag_bits-1:0] victim_tag,
    input  logic [dcache_pkg::word_width-1:0] sel_word,

    // way writes and LRU update
    output logic [dcache_pkg::way_num-1:0] fill_en,
    output logic [dcache_pkg::way_num-1:0] store_en,
    output logic [dcache_pkg::word_width-1:0] fill_word,
    output logic [dcache_pkg::lane_count-1:0] store_strobe,
    output dcache_pkg::word_lanes_t store_word,
    output logic fill_last,
    output logic touch
);

    dcache_pkg::ctrl_state_t state;
    logic [dcache_pkg::offset_bits-1:0] beat;
    logic beat_step;

    // captured request
    logic [dcache_pkg::addr_width-1:0] req_addr;
    logic [dcache_pkg::lane_count-1:0] req_strobe;
    dcache_pkg::word_lanes_t req_wdata;

    logic [dcache_pkg::offset_bits-1:0] req_offset;
    logic [dcache_pkg::index_bits-1:0] req_index;
    logic [dcache_pkg::tag_bits-1:0] req_tag;
    logic req_is_write;

    assign req_offset = req_addr[dcache_pkg::byte_bits +: dcache_pkg::offset_bits];
    assign req_index = req_addr[dcache_pkg::byte_bits + dcache_pkg::offset_bits +:
                                dcache_pkg::index_bits];
    assign req_tag = req_addr[dcache_pkg::addr_width-1 -: dcache_pkg::tag_bits];
    assign req_is_write = |req_strobe;

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::idle && dreq_valid) begin
            req_addr <= dreq_addr;
            req_strobe <= dreq_strobe;
            req_wdata.word <= dreq_wdata;
        end
    end

    assign beat_step = creq_valid && cresp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::idle;
            beat <= '0;
        end else begin
            case (state)
                dcache_pkg::idle: begin
                    if (dreq_valid) begin
                        state <= dcache_pkg::lookup;
                    end
                end
                dcache_pkg::lookup: begin
                    if (any_hit) begin
                        state <= dcache_pkg::respond;
                    end else if (victim_dirty) begin
                        state <= dcache_pkg::writeback;
                    end else begin
                        state <= dcache_pkg::refill;
                    end
                end
                dcache_pkg::writeback: begin
                    if (cresp_ready && cresp_last) begin
                        state <= dcache_pkg::refill;
                    end
                end
                dcache_pkg::refill: begin
                    if (cresp_ready && cresp_last) begin
                        state <= dcache_pkg::respond;
                    end
                end
                default: begin
                    state <= dcache_pkg::idle;
                end
            endcase
            if (beat_step) begin
                beat <= cresp_last ? '0 : beat + 1'b1;
            end
        end
    end

    // bursts always cover the whole line from word 0
    assign creq_valid = (state == dcache_pkg::writeback) || (state == dcache_pkg::refill);
    assign creq_is_write = (state == dcache_pkg::writeback);
    assign creq_addr = {creq_is_write ? victim_tag : req_tag, req_index,
                        {(dcache_pkg::offset_bits + dcache_pkg::byte_bits){1'b0}}};
    assign creq_wdata = sel_word;

    assign index = req_index;
    assign offset = creq_valid ? beat : req_offset;
    assign lookup_tag = req_tag;

    assign fill_word = cresp_rdata;
    assign fill_last = cresp_last;
    assign store_strobe = req_strobe;
    assign store_word = req_wdata;

    // victim_way names the hitting way once the line is present
    always_comb begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            fill_en[w] = (state == dcache_pkg::refill) && cresp_ready && (victim_way == w);
            store_en[w] = (state == dcache_pkg::respond) && req_is_write && (victim_way == w);
        end
    end

    assign touch = (state == dcache_pkg::respond);
    assign dresp_data_ok = (state == dcache_pkg::respond);
    assign dresp_rdata = sel_word;

    creq_addr_held: assert property (
        @(posedge clk) disable iff (reset)
        creq_valid && !cresp_ready |=> creq_valid && $stable(creq_addr)
    );

    // memory ends the burst exactly on the 16th beat
    last_on_final_beat: assert property (
        @(posedge clk) disable iff (reset)
        beat_step && cresp_last |-> beat == dcache_pkg::words_per_line - 1
    );

endmodule

`default_nettype wire

// ==== hw/dcache_way.sv ====
`default_nettype none

module dcache_way (
    input  logic clk,
    input  logic reset,

    input  logic [dcache_pkg::index_bits-1:0] index,
    input  logic [dcache_pkg::offset_bits-1:0] offset,
    input  logic [dcache_pkg::tag_bits-1:0] lookup_tag,

    input  logic fill_en,
    input  logic store_en,
    input  logic [dcache_pkg::word_width-1:0] fill_word,
    input  logic [dcache_pkg::lane_count-1:0] store_strobe,
    input  dcache_pkg::word_lanes_t store_word,
    input  logic fill_last,

    output logic hit,
    output logic dirty,
    output logic [dcache_pkg::tag_bits-1:0] tag_out,
    output logic [dcache_pkg::word_width-1:0] rdata
);

    logic [dcache_pkg::set_num-1:0] valid_q;
    logic [dcache_pkg::set_num-1:0] dirty_q;
    logic [dcache_pkg::tag_bits-1:0] tag_q [dcache_pkg::set_num];
    dcache_pkg::word_lanes_t data_q [dcache_pkg::set_num][dcache_pkg::words_per_line];

    dcache_pkg::word_lanes_t cur_word;
    dcache_pkg::word_lanes_t merged_word;

    // lookup path, no latency
    assign cur_word = data_q[index][offset];
    assign rdata = cur_word.word;
    assign tag_out = tag_q[index];
    assign hit = valid_q[index] && (tag_q[index] == lookup_tag);
    assign dirty = valid_q[index] && dirty_q[index];

    // byte merge for stores
    always_comb begin
        merged_word = cur_word;
        for (int l = 0; l < dcache_pkg::lane_count; l++) begin
            if (store_strobe[l]) begin
                merged_word.lanes[l] = store_word.lanes[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_en && fill_last) begin
                // line complete, clean copy of memory
                valid_q[index] <= 1'b1;
                dirty_q[index] <= 1'b0;
            end else if (store_en) begin
                dirty_q[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[index][offset].word <= fill_word;
            if (fill_last) begin
                tag_q[index] <= lookup_tag;
            end
        end else if (store_en) begin
            data_q[index][offset] <= merged_word;
        end
    end

    // a refill beat and a store never land in the same cycle
    fill_store_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(fill_en && store_en)
    );

    // stores only go to the way that holds the line
    store_needs_hit: assert property (
        @(posedge clk) disable iff (reset) store_en |-> hit
    );

endmodule

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int addr_width = 32;
    localparam int word_width = 64;
    localparam int lane_count = 8;
    localparam int words_per_line = 16;
    localparam int set_num = 8;
    localparam int way_num = 2;

    // address fields, low to high: byte, word offset, set index, tag
    localparam int byte_bits = 3;
    localparam int offset_bits = 4;
    localparam int index_bits = 3;
    localparam int tag_bits = addr_width - index_bits - offset_bits - byte_bits;

    typedef enum logic [2:0] {
        idle,
        lookup,
        writeback,
        refill,
        respond
    } ctrl_state_t;

    // one data word, seen whole or as byte lanes for strobed stores
    typedef union packed {
        logic [word_width-1:0] word;
        logic [lane_count-1:0][7:0] lanes;
    } word_lanes_t;

endpackage

`default_nettype wire
